// File: codma_top.f
codma_pkg.sv
codma_bus_if.sv
codma_bus_arbiter.sv
codma_task_engine.sv
codma_copy_engine.sv
codma_controller.sv
codma_top.sv
tb_codma_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_codma_top \
		-f codma_top.f -o tb_codma_top
	./obj_dir/tb_codma_top | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_codma_top.sv
// Memory model answers in 1 to 4 cycles and faults reads at one address; status pointer is fixed
`timescale 1ns/1ps

module tb_codma_top;

    // 6 tasks, descriptor + status + 64 copy words, up to 5 cycles each, plus margin
    localparam int          WATCHDOG_NS = 6 * (4 + 2 + 2 * 64) * 5 * 4 + 2000;
    localparam logic [31:0] ST_DONE     = 32'd0;
    localparam logic [31:0] ST_PENDING  = 32'd1;
    localparam logic [31:0] ST_ERROR    = 32'd2;
    localparam logic [31:0] STATUS_ADDR = 32'h0000_2000;

    logic        clk_i = 1'b0;
    logic        reset_n_i;
    logic        start_i;
    logic [31:0] task_pointer_i;
    logic [31:0] status_pointer_i;
    logic        busy_o;
    logic        irq_o;
    logic        bus_req_o;
    logic        bus_we_o;
    logic [31:0] bus_addr_o;
    logic [31:0] bus_wdata_o;
    logic [31:0] bus_rdata_i;
    logic        bus_ack_i;
    logic        bus_error_i;

    // Word memory and a log of finished transfers as {we, addr, data}
    logic [31:0] mem [logic [31:0]];
    logic [64:0] bus_log [$];
    logic        err_en;
    logic [31:0] err_addr;
    int          error_count  = 0;
    int          assert_fails = 0;

    codma_top codma_top_i (.*);

    always #2 clk_i = ~clk_i;

    // Unwritten words read back a pattern of the full address
    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : (addr ^ 32'h5a5a_c3c3);
    endfunction

    // ------------------------------
    // Memory model
    // ------------------------------
    always begin : memory_model
        int unsigned wait_cycles;
        @(posedge clk_i);
        #1;
        bus_ack_i   = 1'b0;
        bus_error_i = 1'b0;
        if (reset_n_i && bus_req_o) begin
            // Extra wait of 0 to 3 cycles
            wait_cycles = $urandom_range(3, 0);
            repeat (wait_cycles) begin
                @(posedge clk_i);
                #1;
            end
            if (err_en && !bus_we_o && bus_addr_o == err_addr) begin
                bus_error_i = 1'b1;
            end else begin
                bus_ack_i = 1'b1;
                if (bus_we_o) begin
                    mem[bus_addr_o] = bus_wdata_o;
                end else begin
                    bus_rdata_i = mem_read(bus_addr_o);
                end
                bus_log.push_back({bus_we_o, bus_addr_o, bus_we_o ? bus_wdata_o : bus_rdata_i});
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_irq_single: assert property (@(posedge clk_i) disable iff (!reset_n_i) irq_o |=> !irq_o)
        else begin
            assert_fails++;
            $display("irq_o stayed high for more than one cycle");
        end

    a_busy_irq: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        irq_o == $fell(busy_o))
        else begin
            assert_fails++;
            $display("busy_o did not fall in the irq_o cycle");
        end

    a_req_hold: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (bus_req_o && !bus_ack_i && !bus_error_i) |=>
        (bus_req_o && $stable(bus_addr_o) && $stable(bus_we_o) && $stable(bus_wdata_o)))
        else begin
            assert_fails++;
            $display("Bus request dropped or changed before its response");
        end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        assert (ok) else begin
            $display("Check failed: %s", what);
            error_count++;
        end
    endtask

    // One task from descriptor setup to irq, then checks on memory and bus log
    task automatic run_task(input int n, input logic [31:0] kind, input logic [31:0] len,
                            input bit expect_ok, input bit desc_bad, input bit start_twice);
        logic [31:0] tp;
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] addr;
        logic [31:0] exp_addr;
        bit          we;
        bit          exp_we;
        int          pw;
        int          k;
        int          fetches;
        int          pend_idx;
        int          dst_idx;
        int          last_wr;
        tp  = 32'h0000_1000 + 32'(n) * 32'h10;
        src = 32'h0001_0000 + 32'(n) * 32'h100;
        dst = 32'h0002_0000 + 32'(n) * 32'h100;
        pw  = (kind == 32'd1) ? 8 : 1;
        mem[tp]      = kind;
        mem[tp + 4]  = src;
        mem[tp + 8]  = dst;
        mem[tp + 12] = len;
        for (int i = 0; i < int'(len) / 4; i++) begin
            mem[src + 32'(i) * 4] = $urandom;
        end
        mem[STATUS_ADDR] = 32'hdead_beef;
        bus_log.delete();
        task_pointer_i = tp;
        start_i = 1'b1;
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        if (start_twice) begin
            repeat (3) begin
                @(posedge clk_i);
                #1;
            end
            check_cond(busy_o, "busy_o low during a running task");
            start_i = 1'b1;
            @(posedge clk_i);
            #1;
            start_i = 1'b0;
        end
        while (irq_o !== 1'b1) begin
            @(posedge clk_i);
            #1;
        end
        check_value("busy_o", busy_o, 32'd0);
        check_value("status word", mem_read(STATUS_ADDR), expect_ok ? ST_DONE : ST_ERROR);
        fetches  = 0;
        k        = 0;
        pend_idx = -1;
        dst_idx  = -1;
        last_wr  = -1;
        foreach (bus_log[j]) begin
            we   = bus_log[j][64];
            addr = bus_log[j][63:32];
            if (!we && addr >= tp && addr < tp + 16) begin
                fetches++;
            end
            if (we) begin
                last_wr = j;
            end
            if (we && addr == STATUS_ADDR && bus_log[j][31:0] == ST_PENDING && pend_idx < 0) begin
                pend_idx = j;
            end
            if ((!we && addr >= src && addr < src + len) || (we && addr >= dst && addr < dst + len))
            begin
                if (we && dst_idx < 0) begin
                    dst_idx = j;
                end
                // Per packet, pw reads then pw writes at matching offsets
                exp_we   = (k % (2 * pw)) >= pw;
                exp_addr = (exp_we ? dst : src) + 32'((k / (2 * pw)) * pw * 4 + (k % pw) * 4);
                if (expect_ok) begin
                    check_cond(we == exp_we && addr == exp_addr,
                               $sformatf("copy transfer %0d out of order at 0x%08h", k, addr));
                end
                k++;
            end
        end
        check_value("descriptor reads", 32'(fetches), 32'd4);
        if (desc_bad) begin
            check_value("copy transfers", 32'(k), 32'd0);
        end
        if (expect_ok) begin
            check_value("copy transfers", 32'(k), len / 2);
            check_cond(pend_idx >= 0 && pend_idx < dst_idx, "PENDING not written before data");
            check_cond(last_wr >= 0, "no bus write seen in the task");
            check_value("last write address", bus_log[last_wr][63:32], STATUS_ADDR);
            check_value("last write data", bus_log[last_wr][31:0], ST_DONE);
            for (int i = 0; i < int'(len) / 4; i++) begin
                addr = dst + 32'(i) * 4;
                check_value($sformatf("mem[%08h]", addr), mem_read(addr),
                            mem_read(src + 32'(i) * 4));
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        void'($urandom(32'h5785e9cc));
        reset_n_i        = 1'b0;
        start_i          = 1'b0;
        task_pointer_i   = '0;
        status_pointer_i = STATUS_ADDR;
        bus_rdata_i      = '0;
        bus_ack_i        = 1'b0;
        bus_error_i      = 1'b0;
        err_en           = 1'b0;
        err_addr         = '0;
        repeat (3) @(posedge clk_i);
        #1;
        reset_n_i = 1'b1;
        check_value("bus_req_o", bus_req_o, 32'd0);
        check_value("busy_o", busy_o, 32'd0);
        check_value("irq_o", irq_o, 32'd0);
        run_task(0, 32'd0, 32'd16, 1'b1, 1'b0, 1'b0);
        run_task(1, 32'd1, 32'd64, 1'b1, 1'b0, 1'b0);
        // Unknown kind, then a burst length that is not whole packets
        run_task(2, 32'd3, 32'd16, 1'b0, 1'b1, 1'b0);
        run_task(3, 32'd1, 32'd20, 1'b0, 1'b1, 1'b0);
        // Second source word of task 4 faults
        err_addr = 32'h0001_0404;
        err_en   = 1'b1;
        run_task(4, 32'd0, 32'd16, 1'b0, 1'b0, 1'b0);
        err_en   = 1'b0;
        run_task(5, 32'd1, 32'd32, 1'b1, 1'b0, 1'b1);
        $display("Check errors: %0d, assertion failures: %0d", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Run timed out before all tasks finished");
        $display("tests failed");
        $finish;
    end

endmodule

// File: codma_top.sv
// Copy DMA top; one shared word bus, memory must answer each request with ack or error
`timescale 1ns/1ps

module codma_top (
    input  logic                         clk_i,
    input  logic                         reset_n_i,
    input  logic                         start_i,
    input  logic [codma_pkg::ADDR_W-1:0] task_pointer_i,
    input  logic [codma_pkg::ADDR_W-1:0] status_pointer_i,
    output logic                         busy_o,
    output logic                         irq_o,
    output logic                         bus_req_o,
    output logic                         bus_we_o,
    output logic [codma_pkg::ADDR_W-1:0] bus_addr_o,
    output logic [codma_pkg::DATA_W-1:0] bus_wdata_o,
    input  logic [codma_pkg::DATA_W-1:0] bus_rdata_i,
    input  logic                         bus_ack_i,
    input  logic                         bus_error_i
);
    import codma_pkg::*;

    task_desc_t desc;
    status_e    status_code;
    logic       fetch_start;
    logic       status_start;
    logic       copy_start;
    logic       fetch_done;
    logic       status_done;
    logic       task_fault;
    logic       copy_done;
    logic       copy_fault;

    // One port per engine
    codma_bus_if task_bus ();
    codma_bus_if copy_bus ();

    codma_controller codma_controller_i (
        .clk_i, .reset_n_i, .start_i, .desc_i(desc),
        .fetch_done_i(fetch_done), .status_done_i(status_done), .task_fault_i(task_fault),
        .copy_done_i(copy_done), .copy_fault_i(copy_fault),
        .fetch_start_o(fetch_start), .status_start_o(status_start),
        .status_code_o(status_code), .copy_start_o(copy_start), .busy_o, .irq_o
    );

    codma_task_engine codma_task_engine_i (
        .clk_i, .reset_n_i, .task_pointer_i, .status_pointer_i,
        .fetch_start_i(fetch_start), .status_start_i(status_start),
        .status_code_i(status_code), .desc_o(desc), .fetch_done_o(fetch_done),
        .status_done_o(status_done), .fault_o(task_fault), .bus(task_bus.master)
    );

    codma_copy_engine codma_copy_engine_i (
        .clk_i, .reset_n_i, .copy_start_i(copy_start), .desc_i(desc),
        .copy_done_o(copy_done), .fault_o(copy_fault), .bus(copy_bus.master)
    );

    codma_bus_arbiter codma_bus_arbiter_i (
        .clk_i, .reset_n_i, .task_bus(task_bus.arbiter), .copy_bus(copy_bus.arbiter),
        .bus_req_o, .bus_we_o, .bus_addr_o, .bus_wdata_o,
        .bus_rdata_i, .bus_ack_i, .bus_error_i
    );

endmodule

// File: codma_controller.sv
// Task sequencer; DONE never overtakes PENDING, and ERROR waits until both engines are quiet
`timescale 1ns/1ps

module codma_controller (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  start_i,
    input  codma_pkg::task_desc_t desc_i,
    input  logic                  fetch_done_i,
    input  logic                  status_done_i,
    input  logic                  task_fault_i,
    input  logic                  copy_done_i,
    input  logic                  copy_fault_i,
    output logic                  fetch_start_o,
    output logic                  status_start_o,
    output codma_pkg::status_e    status_code_o,
    output logic                  copy_start_o,
    output logic                  busy_o,
    output logic                  irq_o
);
    import codma_pkg::*;

    ctrl_state_e state_r;
    logic        fetched_r;
    logic        copy_busy_r;
    logic        pend_r;
    logic        desc_ok;
    logic        quiet;
    logic        fault;
    logic        final_done;

    // ------------------------------
    // Descriptor check
    // ------------------------------
    assign desc_ok = (desc_i.len != '0) &&
        (((desc_i.kind == TASK_SINGLE) && (desc_i.len % BYTES_PER_WORD == 0)) ||
         ((desc_i.kind == TASK_BURST) && (desc_i.len % (PKT_WORDS * BYTES_PER_WORD) == 0)));

    assign quiet      = !copy_busy_r && !pend_r;
    assign fault      = task_fault_i || copy_fault_i;
    // Final status write has ended, cleanly or not
    assign final_done = (state_r == CTRL_FINISH && status_done_i) ||
                        (state_r == CTRL_WAIT_STATUS && (status_done_i || task_fault_i));

    assign fetch_start_o  = (state_r == CTRL_IDLE) && start_i;
    assign copy_start_o   = (state_r == CTRL_FETCH) && fetched_r && desc_ok;
    assign status_start_o = copy_start_o ||
                            (state_r == CTRL_COPY && quiet) ||
                            (state_r == CTRL_ERROR && quiet);
    assign status_code_o  = (state_r == CTRL_FETCH) ? STATUS_PENDING :
                            (state_r == CTRL_COPY)  ? STATUS_DONE : STATUS_ERROR;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_r     <= CTRL_IDLE;
            fetched_r   <= 1'b0;
            copy_busy_r <= 1'b0;
            pend_r      <= 1'b0;
            busy_o      <= 1'b0;
            irq_o       <= 1'b0;
        end else begin
            fetched_r <= fetch_done_i;
            irq_o     <= final_done;
            // Open jobs on the two engines
            if (copy_start_o) begin
                copy_busy_r <= 1'b1;
            end else if (copy_done_i || copy_fault_i) begin
                copy_busy_r <= 1'b0;
            end
            if (copy_start_o) begin
                pend_r <= 1'b1;
            end else if (status_done_i || task_fault_i) begin
                pend_r <= 1'b0;
            end
            case (state_r)
                CTRL_IDLE: if (start_i) begin
                    busy_o  <= 1'b1;
                    state_r <= CTRL_FETCH;
                end
                CTRL_FETCH: if (task_fault_i || (fetched_r && !desc_ok)) begin
                    state_r <= CTRL_ERROR;
                end else if (fetched_r) begin
                    state_r <= CTRL_COPY;
                end
                CTRL_COPY: if (fault) begin
                    state_r <= CTRL_ERROR;
                end else if (quiet) begin
                    state_r <= CTRL_FINISH;
                end
                CTRL_FINISH: if (task_fault_i) begin
                    state_r <= CTRL_ERROR;
                end
                CTRL_ERROR: if (quiet) begin
                    state_r <= CTRL_WAIT_STATUS;
                end
                default: ;
            endcase
            // Task ends with irq and busy together
            if (final_done) begin
                busy_o  <= 1'b0;
                state_r <= CTRL_IDLE;
            end
        end
    end

    // Copy only starts on a supported kind with a whole number of packets
    a_copy_valid: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        copy_start_o |-> ((desc_i.len != '0) && (desc_i.len[1:0] == 2'b00) &&
            ((desc_i.kind == TASK_SINGLE) ||
             ((desc_i.kind == TASK_BURST) && (desc_i.len[4:0] == 5'd0)))));

    a_irq_pulse: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        irq_o |=> !irq_o);

endmodule

// File: codma_copy_engine.sv
// Packet copy through an 8-word buffer; length must already be a whole number of packets
`timescale 1ns/1ps

module codma_copy_engine (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  copy_start_i,
    input  codma_pkg::task_desc_t desc_i,
    output logic                  copy_done_o,
    output logic                  fault_o,
    codma_bus_if.master           bus
);
    import codma_pkg::*;

    copy_state_e          state_r;
    logic [ADDR_W-1:0]    src_r;
    logic [ADDR_W-1:0]    dst_r;
    logic [ADDR_W-1:0]    remain_r;
    logic [BUF_IDX_W-1:0] idx_r;
    logic                 burst_r;
    logic                 req_r;
    logic [DATA_W-1:0]    buf_r [PKT_WORDS];
    logic [BUF_IDX_W-1:0] pkt_last;
    logic [ADDR_W-1:0]    pkt_bytes;
    logic [ADDR_W-1:0]    offset;
    logic                 pkt_end;

    // ------------------------------
    // Packet geometry
    // ------------------------------
    assign pkt_last  = burst_r ? BUF_IDX_W'(PKT_WORDS - 1) : '0;
    assign pkt_bytes = burst_r ? ADDR_W'(PKT_WORDS * BYTES_PER_WORD) : ADDR_W'(BYTES_PER_WORD);
    assign offset    = ADDR_W'(idx_r) * ADDR_W'(BYTES_PER_WORD);
    assign pkt_end   = (idx_r == pkt_last);

    assign bus.req   = req_r;
    assign bus.we    = (state_r == COPY_WRITE);
    assign bus.addr  = (state_r == COPY_WRITE) ? dst_r + offset : src_r + offset;
    assign bus.wdata = buf_r[idx_r];

    // Last write of the last packet
    assign copy_done_o = (state_r == COPY_WRITE) && req_r && bus.ack && pkt_end
                         && (remain_r == pkt_bytes);
    assign fault_o     = req_r && bus.error;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_r  <= COPY_IDLE;
            src_r    <= '0;
            dst_r    <= '0;
            remain_r <= '0;
            idx_r    <= '0;
            burst_r  <= 1'b0;
            req_r    <= 1'b0;
        end else if (state_r == COPY_IDLE) begin
            if (copy_start_i) begin
                src_r    <= desc_i.src;
                dst_r    <= desc_i.dst;
                remain_r <= desc_i.len;
                burst_r  <= (desc_i.kind == TASK_BURST);
                idx_r    <= '0;
                req_r    <= 1'b1;
                state_r  <= COPY_READ;
            end
        end else if (req_r && bus.error) begin
            // Drop the request and give up the task
            req_r   <= 1'b0;
            state_r <= COPY_IDLE;
        end else if (req_r && bus.ack) begin
            req_r <= 1'b0;
            idx_r <= pkt_end ? '0 : idx_r + 1'b1;
            if (pkt_end && state_r == COPY_READ) begin
                // Buffer full, drain it
                state_r <= COPY_WRITE;
            end else if (pkt_end) begin
                src_r    <= src_r + pkt_bytes;
                dst_r    <= dst_r + pkt_bytes;
                remain_r <= remain_r - pkt_bytes;
                state_r  <= (remain_r == pkt_bytes) ? COPY_IDLE : COPY_READ;
            end
        end else begin
            // Reissue after the idle cycle that follows each ack
            req_r <= 1'b1;
        end
    end

    // Packet buffer, written by the reads
    always_ff @(posedge clk_i) begin
        if (state_r == COPY_READ && req_r && bus.ack) begin
            buf_r[idx_r] <= bus.rdata;
        end
    end

    // Index stays within the packet and inside the bytes still to move
    a_idx_range: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (state_r != COPY_IDLE) |-> ((idx_r <= pkt_last) && (offset < remain_r)));

endmodule

// File: codma_task_engine.sv
// Descriptor fetch and status writes; pointers must stay stable while the engine is active
`timescale 1ns/1ps

module codma_task_engine (
    input  logic                         clk_i,
    input  logic                         reset_n_i,
    input  logic [codma_pkg::ADDR_W-1:0] task_pointer_i,
    input  logic [codma_pkg::ADDR_W-1:0] status_pointer_i,
    input  logic                         fetch_start_i,
    input  logic                         status_start_i,
    input  codma_pkg::status_e           status_code_i,
    output codma_pkg::task_desc_t        desc_o,
    output logic                         fetch_done_o,
    output logic                         status_done_o,
    output logic                         fault_o,
    codma_bus_if.master                  bus
);
    import codma_pkg::*;

    logic       fetch_active_r;
    logic       status_active_r;
    logic       req_r;
    logic [1:0] word_cnt_r;
    status_e    code_r;
    logic       last_word;

    assign last_word = (word_cnt_r == 2'(DESC_WORDS - 1));

    // ------------------------------
    // Bus request
    // ------------------------------
    assign bus.req   = req_r;
    // Only status traffic writes
    assign bus.we    = status_active_r;
    assign bus.addr  = status_active_r ? status_pointer_i
                     : task_pointer_i + ADDR_W'(word_cnt_r) * ADDR_W'(BYTES_PER_WORD);
    assign bus.wdata = code_r;

    assign fetch_done_o  = fetch_active_r && req_r && bus.ack && last_word;
    assign status_done_o = status_active_r && req_r && bus.ack;
    assign fault_o       = req_r && bus.error;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            fetch_active_r  <= 1'b0;
            status_active_r <= 1'b0;
            req_r           <= 1'b0;
            word_cnt_r      <= '0;
            code_r          <= STATUS_DONE;
        end else if (fetch_start_i) begin
            fetch_active_r <= 1'b1;
            word_cnt_r     <= '0;
            req_r          <= 1'b1;
        end else if (status_start_i) begin
            // Code is latched here and held for the whole write
            status_active_r <= 1'b1;
            code_r          <= status_code_i;
            req_r           <= 1'b1;
        end else if (req_r && bus.error) begin
            // Abandon whatever was running
            fetch_active_r  <= 1'b0;
            status_active_r <= 1'b0;
            req_r           <= 1'b0;
        end else if (req_r && bus.ack) begin
            req_r           <= 1'b0;
            status_active_r <= 1'b0;
            if (fetch_active_r) begin
                word_cnt_r <= word_cnt_r + 2'd1;
                if (last_word) begin
                    fetch_active_r <= 1'b0;
                end
            end
        end else if (fetch_active_r) begin
            // Next descriptor word, one idle cycle after each ack
            req_r <= 1'b1;
        end
    end

    // Descriptor fields fill in address order
    always_ff @(posedge clk_i) begin
        if (fetch_active_r && req_r && bus.ack) begin
            case (word_cnt_r)
                2'd0:    desc_o.kind <= bus.rdata;
                2'd1:    desc_o.src  <= bus.rdata;
                2'd2:    desc_o.dst  <= bus.rdata;
                default: desc_o.len  <= bus.rdata;
            endcase
        end
    end

    // Controller never overlaps two jobs on this engine
    a_no_overlap: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (fetch_start_i || status_start_i) |-> !(fetch_active_r || status_active_r));

endmodule

// File: codma_bus_arbiter.sv
// Fixed priority to the task engine; grant locked until ack or error, no added cycle on the request
`timescale 1ns/1ps

module codma_bus_arbiter (
    input  logic                        clk_i,
    input  logic                        reset_n_i,
    codma_bus_if.arbiter                task_bus,
    codma_bus_if.arbiter                copy_bus,
    output logic                        bus_req_o,
    output logic                        bus_we_o,
    output logic [codma_pkg::ADDR_W-1:0] bus_addr_o,
    output logic [codma_pkg::DATA_W-1:0] bus_wdata_o,
    input  logic [codma_pkg::DATA_W-1:0] bus_rdata_i,
    input  logic                        bus_ack_i,
    input  logic                        bus_error_i
);
    import codma_pkg::*;

    logic locked_r;
    logic grant_copy_r;
    logic grant_copy;
    logic resp;

    assign resp = bus_ack_i || bus_error_i;

    // Keep the locked owner, else task engine first
    assign grant_copy = locked_r ? grant_copy_r : (!task_bus.req && copy_bus.req);

    // Request mux
    assign bus_req_o   = grant_copy ? copy_bus.req   : task_bus.req;
    assign bus_we_o    = grant_copy ? copy_bus.we    : task_bus.we;
    assign bus_addr_o  = grant_copy ? copy_bus.addr  : task_bus.addr;
    assign bus_wdata_o = grant_copy ? copy_bus.wdata : task_bus.wdata;

    // Responses reach the owner only
    assign task_bus.ack   = bus_ack_i   && !grant_copy;
    assign task_bus.error = bus_error_i && !grant_copy;
    assign task_bus.rdata = grant_copy ? '0 : bus_rdata_i;
    assign copy_bus.ack   = bus_ack_i   && grant_copy;
    assign copy_bus.error = bus_error_i && grant_copy;
    assign copy_bus.rdata = grant_copy ? bus_rdata_i : '0;

    // Lock while a request waits for its response
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            locked_r     <= 1'b0;
            grant_copy_r <= 1'b0;
        end else begin
            locked_r     <= bus_req_o && !resp;
            grant_copy_r <= grant_copy;
        end
    end

    // Open transaction keeps the same request on the bus into the next cycle
    a_grant_hold: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (bus_req_o && !resp) |=>
        (bus_req_o && $stable(bus_we_o) && $stable(bus_addr_o) && $stable(bus_wdata_o)));

    // A response only lands on a master that is asking
    a_resp_owner: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        ((task_bus.ack || task_bus.error) |-> task_bus.req) and
        ((copy_bus.ack || copy_bus.error) |-> copy_bus.req));

endmodule

// File: codma_bus_if.sv
// One master port of the word bus; a single request outstanding, req held until ack or error
`timescale 1ns/1ps

interface codma_bus_if;
    import codma_pkg::*;

    // Request side, driven by the master
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // Response side, driven by the arbiter
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              error;

    modport master (
        output req, we, addr, wdata,
        input  rdata, ack, error
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ack, error
    );

endinterface

// File: codma_pkg.sv
// Shared widths, descriptor layout and codes; packet size and widths are fixed by the descriptor format
package codma_pkg;

    // ------------------------------
    // Bus and packet geometry
    // ------------------------------
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    // Words in one burst packet, 32 bytes
    localparam int PKT_WORDS      = 8;
    localparam int BUF_IDX_W      = 3;
    // Descriptor is type, source, destination, length
    localparam int DESC_WORDS     = 4;

    // ------------------------------
    // Descriptor encodings
    // ------------------------------
    // Any other kind value is rejected by the controller
    typedef enum logic [DATA_W-1:0] {
        TASK_SINGLE = 32'd0,
        TASK_BURST  = 32'd1
    } task_type_e;

    // Word written to the status pointer
    typedef enum logic [DATA_W-1:0] {
        STATUS_DONE    = 32'd0,
        STATUS_PENDING = 32'd1,
        STATUS_ERROR   = 32'd2
    } status_e;

    // Kind is kept raw so invalid values survive for checking
    typedef struct packed {
        logic [DATA_W-1:0] kind;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [DATA_W-1:0] len;
    } task_desc_t;

    // ------------------------------
    // State machines
    // ------------------------------
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_FETCH,
        CTRL_COPY,
        CTRL_FINISH,
        CTRL_ERROR,
        CTRL_WAIT_STATUS
    } ctrl_state_e;

    typedef enum logic [1:0] {
        COPY_IDLE,
        COPY_READ,
        COPY_WRITE
    } copy_state_e;

endpackage
